// File: common/bp_consts.svh
// ------------------------------
// sizes for a 16-byte fetch block of 4-byte lanes
// no compressed instructions
// ------------------------------

`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// instruction lanes in one fetch block
`define BP_LANES 4

// global history width
// also the counter-table index width, 64 counters per lane
`define BP_BHR_W 6

// entries in each lane's BTB, indexed by pc[7:4]
`define BP_BTB_ENTRIES 16

// virtual address width
`define BP_VADDR_W 32

`endif

// File: common/bp_pkg.sv
// ------------------------------
// types shared by the predictor blocks
// ------------------------------

`default_nettype none

`include "bp_consts.svh"

package bp_pkg;

  // ------------------------------
  // addresses and history
  // ------------------------------

  // fetch pc or branch target
  typedef logic [`BP_VADDR_W-1:0] vaddr_t;

  // global history, same width as a counter-table index
  typedef logic [`BP_BHR_W-1:0] bhr_t;

  // one bit per instruction lane
  typedef logic [`BP_LANES-1:0] lane_mask_t;

  // ------------------------------
  // direction counters
  // ------------------------------

  // 2-bit saturating counter, msb set means predict taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'd0,
    WEAK_NT   = 2'd1,
    WEAK_T    = 2'd2,
    STRONG_T  = 2'd3
  } ctr_e;

endpackage

`default_nettype wire

// File: hw/btb/bp_btb.sv
// ------------------------------
// direct-mapped, one table per lane, written on taken commits
// a commit in the s0 cycle is not seen by that lookup
// ------------------------------

`default_nettype none

`include "bp_consts.svh"

module bp_btb (
  input  wire logic               i_clk,
  input  wire logic               i_reset_n,

  // fetch search
  input  wire logic               i_s0_valid,
  input  wire bp_pkg::vaddr_t     i_s0_pc,

  // commit update
  input  wire logic               i_cmt_valid,
  input  wire bp_pkg::vaddr_t     i_cmt_pc,
  input  wire logic               i_cmt_taken,
  input  wire logic               i_cmt_is_cond,
  input  wire bp_pkg::vaddr_t     i_cmt_target,

  // search results
  output bp_pkg::lane_mask_t      o_s1_hit,
  output bp_pkg::lane_mask_t      o_s1_is_cond,
  output bp_pkg::lane_mask_t      o_s2_hit,
  output bp_pkg::vaddr_t          o_s2_target [`BP_LANES]
);

  localparam int LANE_W  = $clog2(`BP_LANES);
  localparam int IDX_W   = $clog2(`BP_BTB_ENTRIES);
  localparam int IDX_LSB = 2 + LANE_W;
  localparam int TAG_LSB = IDX_LSB + IDX_W;
  localparam int TAG_W   = `BP_VADDR_W - TAG_LSB;

  logic [LANE_W-1:0]  w_cmt_lane;
  logic [IDX_W-1:0]   w_cmt_idx;
  logic [TAG_W-1:0]   w_cmt_tag;
  logic               w_wr_en;
  logic [IDX_W-1:0]   w_s0_idx;
  logic [TAG_W-1:0]   w_s0_tag;

  bp_pkg::lane_mask_t w_s0_hit;
  bp_pkg::lane_mask_t w_s0_is_cond;
  bp_pkg::vaddr_t     w_s0_target [`BP_LANES];
  bp_pkg::vaddr_t     r_s1_target [`BP_LANES];

  assign w_cmt_lane = i_cmt_pc[2 +: LANE_W];
  assign w_cmt_idx  = i_cmt_pc[IDX_LSB +: IDX_W];
  assign w_cmt_tag  = i_cmt_pc[TAG_LSB +: TAG_W];
  assign w_wr_en    = i_cmt_valid & i_cmt_taken;

  assign w_s0_idx = i_s0_pc[IDX_LSB +: IDX_W];
  assign w_s0_tag = i_s0_pc[TAG_LSB +: TAG_W];

  // ------------------------------
  // per-lane entry arrays
  // ------------------------------
  for (genvar g_lane = 0; g_lane < `BP_LANES; g_lane++) begin : g_lane_btb
    logic [`BP_BTB_ENTRIES-1:0] r_valid;
    logic [TAG_W-1:0]           r_tag    [`BP_BTB_ENTRIES];
    bp_pkg::vaddr_t             r_target [`BP_BTB_ENTRIES];
    logic                       r_is_cond[`BP_BTB_ENTRIES];
    logic                       w_lane_wr;

    assign w_lane_wr = w_wr_en & (w_cmt_lane == LANE_W'(g_lane));

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_valid <= '0;
      end else if (w_lane_wr) begin
        r_valid[w_cmt_idx] <= 1'b1;
      end
    end

    always_ff @(posedge i_clk) begin
      if (w_lane_wr) begin
        r_tag[w_cmt_idx]     <= w_cmt_tag;
        r_target[w_cmt_idx]  <= i_cmt_target;
        r_is_cond[w_cmt_idx] <= i_cmt_is_cond;
      end
    end

    // tag compare against the s0 pc
    assign w_s0_hit[g_lane]     = i_s0_valid & r_valid[w_s0_idx] &
                                  (r_tag[w_s0_idx] == w_s0_tag);
    assign w_s0_is_cond[g_lane] = r_is_cond[w_s0_idx];
    assign w_s0_target[g_lane]  = r_target[w_s0_idx];
  end

  // ------------------------------
  // s1 / s2 staging
  // ------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_s1_hit     <= '0;
      o_s1_is_cond <= '0;
      o_s2_hit     <= '0;
    end else begin
      o_s1_hit     <= w_s0_hit;
      o_s1_is_cond <= w_s0_is_cond;
      o_s2_hit     <= o_s1_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_target <= w_s0_target;
    o_s2_target <= r_s1_target;
  end

endmodule

`default_nettype wire

// File: hw/gshare/bp_gshare.sv
// ------------------------------
// counters are flops reset to WEAK_T, BHR resets to zero
// s1 history chain starts from the current BHR
// ------------------------------

`default_nettype none

`include "bp_consts.svh"

module bp_gshare (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,

  // fetch search
  input  wire logic                i_s0_valid,
  input  wire bp_pkg::vaddr_t      i_s0_pc,

  // commit training
  input  wire logic                i_cmt_valid,
  input  wire bp_pkg::vaddr_t      i_cmt_pc,
  input  wire logic                i_cmt_is_cond,
  input  wire logic                i_cmt_taken,
  input  wire logic                i_cmt_mispredict,
  input  wire bp_pkg::bhr_t        i_cmt_index,
  input  wire bp_pkg::ctr_e        i_cmt_ctr,
  input  wire bp_pkg::bhr_t        i_cmt_bhr,

  // from the BTB
  input  wire bp_pkg::lane_mask_t  i_s1_hit,
  input  wire bp_pkg::lane_mask_t  i_s1_is_cond,
  input  wire bp_pkg::lane_mask_t  i_s2_hit,

  // s2 prediction
  output logic                     o_s2_valid,
  output bp_pkg::bhr_t             o_s2_index [`BP_LANES],
  output bp_pkg::ctr_e             o_s2_ctr   [`BP_LANES],
  output bp_pkg::bhr_t             o_s2_bhr   [`BP_LANES],
  output bp_pkg::lane_mask_t       o_s2_taken_lanes
);

  localparam int LANE_W  = $clog2(`BP_LANES);
  localparam int TABLE_N = 2 ** `BP_BHR_W;

  bp_pkg::bhr_t      r_bhr;
  bp_pkg::bhr_t      w_s0_index;
  bp_pkg::bhr_t      r_s1_index;
  logic              r_s1_valid;
  bp_pkg::ctr_e      r_s1_ctr      [`BP_LANES];
  bp_pkg::bhr_t      w_s1_lane_bhr [`BP_LANES];
  bp_pkg::bhr_t      w_s1_chain_bhr;
  logic              w_s1_update;

  logic [LANE_W-1:0] w_cmt_lane;
  logic              w_train;
  bp_pkg::ctr_e      w_upd_ctr;
  logic              w_rollback;
  bp_pkg::bhr_t      w_rollback_bhr;

  assign w_s0_index = r_bhr ^ i_s0_pc[4 +: `BP_BHR_W];

  // ------------------------------
  // commit training
  // ------------------------------
  assign w_cmt_lane = i_cmt_pc[2 +: LANE_W];
  assign w_train    = i_cmt_valid & i_cmt_is_cond;

  // saturating step from the counter seen at prediction time
  always_comb begin
    case (i_cmt_ctr)
      bp_pkg::STRONG_NT: w_upd_ctr = i_cmt_taken ? bp_pkg::WEAK_NT  : bp_pkg::STRONG_NT;
      bp_pkg::WEAK_NT:   w_upd_ctr = i_cmt_taken ? bp_pkg::WEAK_T   : bp_pkg::STRONG_NT;
      bp_pkg::WEAK_T:    w_upd_ctr = i_cmt_taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_NT;
      default:           w_upd_ctr = i_cmt_taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_T;
    endcase
  end

  // per-lane counter tables
  for (genvar g_lane = 0; g_lane < `BP_LANES; g_lane++) begin : g_lane_tbl
    bp_pkg::ctr_e r_ctr [TABLE_N];
    bp_pkg::ctr_e w_s0_ctr;
    logic         w_lane_wr;

    assign w_lane_wr = w_train & (w_cmt_lane == LANE_W'(g_lane));

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        for (int i = 0; i < TABLE_N; i++) begin
          r_ctr[i] <= bp_pkg::WEAK_T;
        end
      end else if (w_lane_wr) begin
        r_ctr[i_cmt_index] <= w_upd_ctr;
      end
    end

    // same-cycle write bypass into the s0 read
    assign w_s0_ctr = (w_lane_wr && (i_cmt_index == w_s0_index)) ? w_upd_ctr :
                      r_ctr[w_s0_index];

    always_ff @(posedge i_clk) begin
      r_s1_ctr[g_lane] <= w_s0_ctr;
    end
  end

  // ------------------------------
  // s1 speculative history
  // ------------------------------
  always_comb begin
    bp_pkg::bhr_t v_chain;
    v_chain = r_bhr;
    for (int c = 0; c < `BP_LANES; c++) begin
      w_s1_lane_bhr[c] = v_chain;
      if (i_s1_hit[c] && i_s1_is_cond[c]) begin
        v_chain = {v_chain[`BP_BHR_W-2:0], r_s1_ctr[c][1]};
      end
    end
    w_s1_chain_bhr = v_chain;
  end

  assign w_s1_update    = r_s1_valid & (|(i_s1_hit & i_s1_is_cond));
  assign w_rollback     = i_cmt_valid & i_cmt_is_cond & i_cmt_mispredict;
  assign w_rollback_bhr = {i_cmt_bhr[`BP_BHR_W-2:0], i_cmt_taken};

  // rollback wins over the speculative update
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_bhr <= '0;
    end else if (w_rollback) begin
      r_bhr <= w_rollback_bhr;
    end else if (w_s1_update) begin
      r_bhr <= w_s1_chain_bhr;
    end
  end

  // ------------------------------
  // pipeline and s2 outputs
  // ------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      o_s2_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_s0_valid;
      o_s2_valid <= r_s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_index <= w_s0_index;
    o_s2_ctr   <= r_s1_ctr;
    o_s2_bhr   <= w_s1_lane_bhr;
    for (int c = 0; c < `BP_LANES; c++) begin
      o_s2_index[c] <= r_s1_index;
    end
  end

  always_comb begin
    for (int c = 0; c < `BP_LANES; c++) begin
      o_s2_taken_lanes[c] = o_s2_ctr[c][1] & i_s2_hit[c];
    end
  end

endmodule

`default_nettype wire

// File: hw/gshare/bp_taken_select.sv
// ------------------------------
// purely combinational, lowest taken lane wins
// ------------------------------

`default_nettype none

`include "bp_consts.svh"

module bp_taken_select (
  input  wire bp_pkg::lane_mask_t  i_taken_lanes,
  input  wire bp_pkg::vaddr_t      i_target [`BP_LANES],
  output logic                     o_predict_valid,
  output bp_pkg::vaddr_t           o_target,
  output bp_pkg::lane_mask_t       o_taken_lanes
);

  // ------------------------------
  // first taken lane
  // ------------------------------

  // x & -x keeps only the lowest set bit
  assign o_taken_lanes = i_taken_lanes & (~i_taken_lanes + bp_pkg::lane_mask_t'(1));

  assign o_predict_valid = |i_taken_lanes;

  // ------------------------------
  // one-hot target mux
  // ------------------------------
  always_comb begin
    o_target = '0;
    for (int c = 0; c < `BP_LANES; c++) begin
      // at most one lane contributes
      o_target = o_target | ({`BP_VADDR_W{o_taken_lanes[c]}} & i_target[c]);
    end
  end

endmodule

`default_nettype wire

// File: hw/bp_top.sv
// ------------------------------
// lookup result 2 cycles after s0, no back-pressure
// commits take effect on the next cycle
// ------------------------------

`default_nettype none

`include "bp_consts.svh"

module bp_top (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,

  // fetch search
  input  wire logic                i_s0_valid,
  input  wire bp_pkg::vaddr_t      i_s0_pc,

  // commit port
  input  wire logic                i_cmt_valid,
  input  wire bp_pkg::vaddr_t      i_cmt_pc,
  input  wire logic                i_cmt_is_cond,
  input  wire logic                i_cmt_taken,
  input  wire logic                i_cmt_mispredict,
  input  wire bp_pkg::vaddr_t      i_cmt_target,
  input  wire bp_pkg::bhr_t        i_cmt_index,
  input  wire bp_pkg::ctr_e        i_cmt_ctr,
  input  wire bp_pkg::bhr_t        i_cmt_bhr,

  // s2 prediction
  output logic                     o_s2_valid,
  output logic                     o_s2_predict_valid,
  output bp_pkg::vaddr_t           o_s2_predict_target,
  output bp_pkg::lane_mask_t       o_s2_taken_lanes,
  output bp_pkg::bhr_t             o_s2_index [`BP_LANES],
  output bp_pkg::ctr_e             o_s2_ctr   [`BP_LANES],
  output bp_pkg::bhr_t             o_s2_bhr   [`BP_LANES]
);

  bp_pkg::lane_mask_t w_s1_hit;
  bp_pkg::lane_mask_t w_s1_is_cond;
  bp_pkg::lane_mask_t w_s2_hit;
  bp_pkg::vaddr_t     w_s2_target [`BP_LANES];
  bp_pkg::lane_mask_t w_s2_taken_lanes;

  bp_btb u_btb (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_s0_valid    (i_s0_valid),
    .i_s0_pc       (i_s0_pc),
    .i_cmt_valid   (i_cmt_valid),
    .i_cmt_pc      (i_cmt_pc),
    .i_cmt_taken   (i_cmt_taken),
    .i_cmt_is_cond (i_cmt_is_cond),
    .i_cmt_target  (i_cmt_target),
    .o_s1_hit      (w_s1_hit),
    .o_s1_is_cond  (w_s1_is_cond),
    .o_s2_hit      (w_s2_hit),
    .o_s2_target   (w_s2_target)
  );

  bp_gshare u_gshare (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_s0_valid       (i_s0_valid),
    .i_s0_pc          (i_s0_pc),
    .i_cmt_valid      (i_cmt_valid),
    .i_cmt_pc         (i_cmt_pc),
    .i_cmt_is_cond    (i_cmt_is_cond),
    .i_cmt_taken      (i_cmt_taken),
    .i_cmt_mispredict (i_cmt_mispredict),
    .i_cmt_index      (i_cmt_index),
    .i_cmt_ctr        (i_cmt_ctr),
    .i_cmt_bhr        (i_cmt_bhr),
    .i_s1_hit         (w_s1_hit),
    .i_s1_is_cond     (w_s1_is_cond),
    .i_s2_hit         (w_s2_hit),
    .o_s2_valid       (o_s2_valid),
    .o_s2_index       (o_s2_index),
    .o_s2_ctr         (o_s2_ctr),
    .o_s2_bhr         (o_s2_bhr),
    .o_s2_taken_lanes (w_s2_taken_lanes)
  );

  bp_taken_select u_taken_select (
    .i_taken_lanes   (w_s2_taken_lanes),
    .i_target        (w_s2_target),
    .o_predict_valid (o_s2_predict_valid),
    .o_target        (o_s2_predict_target),
    .o_taken_lanes   (o_s2_taken_lanes)
  );

endmodule

`default_nettype wire

// File: verification/bp_props.sv
// ------------------------------
// bound into bp_top, checks s2 timing and selector shape
// ------------------------------

`default_nettype none

module bp_props (
  input wire logic               i_clk,
  input wire logic               i_reset_n,
  input wire logic               i_s0_valid,
  input wire logic               i_s2_valid,
  input wire logic               i_s2_predict_valid,
  input wire bp_pkg::lane_mask_t i_s2_taken_lanes
);
  timeunit 1ns;
  timeprecision 100ps;

  // fixed two-cycle lookup latency
  a_valid_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_s2_valid == $past(i_s0_valid, 2))
    else $error("s2 valid does not follow s0 valid by two cycles");

  a_predict_in_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_s2_predict_valid |-> i_s2_valid)
    else $error("prediction reported without a valid s2 lookup");

  // selector keeps only the first taken lane
  a_taken_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(i_s2_taken_lanes))
    else $error("more than one taken lane reported");

  a_reset_quiet: assert property (@(posedge i_clk)
    !i_reset_n |-> (!i_s2_valid && !i_s2_predict_valid))
    else $error("valid outputs high during reset");

endmodule

`default_nettype wire

// File: verification/bp_tb.sv
// ------------------------------
// cycle-exact shadow of the predictor, every clock after reset steps the model
// lookup results compared at the falling edge, first mismatch stops the run
// ------------------------------

`default_nettype none

`include "bp_consts.svh"

module bp_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD_NS   = 4;
  localparam int N_RANDOM        = 300;
  localparam int N_OPS           = N_RANDOM + 40;
  localparam int WATCHDOG_CYCLES = N_OPS * 20 + 200;
  localparam int TABLE_N         = 2 ** `BP_BHR_W;

  typedef struct packed {
    logic                                pv;
    bp_pkg::vaddr_t                      tgt;
    bp_pkg::lane_mask_t                  taken;
    bp_pkg::bhr_t                        index;
    logic [`BP_LANES-1:0][1:0]           ctr;
    logic [`BP_LANES-1:0][`BP_BHR_W-1:0] bhr;
  } expect_t;

  // DUT ports
  logic               i_clk;
  logic               i_reset_n;
  logic               i_s0_valid;
  bp_pkg::vaddr_t     i_s0_pc;
  logic               i_cmt_valid;
  bp_pkg::vaddr_t     i_cmt_pc;
  logic               i_cmt_is_cond;
  logic               i_cmt_taken;
  logic               i_cmt_mispredict;
  bp_pkg::vaddr_t     i_cmt_target;
  bp_pkg::bhr_t       i_cmt_index;
  bp_pkg::ctr_e       i_cmt_ctr;
  bp_pkg::bhr_t       i_cmt_bhr;
  logic               o_s2_valid;
  logic               o_s2_predict_valid;
  bp_pkg::vaddr_t     o_s2_predict_target;
  bp_pkg::lane_mask_t o_s2_taken_lanes;
  bp_pkg::bhr_t       o_s2_index [`BP_LANES];
  bp_pkg::ctr_e       o_s2_ctr   [`BP_LANES];
  bp_pkg::bhr_t       o_s2_bhr   [`BP_LANES];

  // stimulus for the next cycle
  logic               st_s0_v;
  bp_pkg::vaddr_t     st_pc;
  logic               st_c_v;
  bp_pkg::vaddr_t     st_c_pc;
  logic               st_c_cond;
  logic               st_c_taken;
  logic               st_c_mis;
  bp_pkg::vaddr_t     st_c_tgt;
  bp_pkg::bhr_t       st_c_idx;
  logic [1:0]         st_c_ctr;
  bp_pkg::bhr_t       st_c_bhr;

  // ------------------------------
  // shadow state
  // ------------------------------
  bp_pkg::bhr_t       m_bhr;
  logic [1:0]         m_ctr   [`BP_LANES][TABLE_N];
  logic               m_bv    [`BP_LANES][`BP_BTB_ENTRIES];
  logic [23:0]        m_btag  [`BP_LANES][`BP_BTB_ENTRIES];
  bp_pkg::vaddr_t     m_btgt  [`BP_LANES][`BP_BTB_ENTRIES];
  logic               m_bcond [`BP_LANES][`BP_BTB_ENTRIES];
  logic               m1_valid;
  bp_pkg::bhr_t       m1_index;
  logic [1:0]         m1_ctr  [`BP_LANES];
  bp_pkg::lane_mask_t m1_hit;
  bp_pkg::lane_mask_t m1_cond;
  bp_pkg::vaddr_t     m1_tgt  [`BP_LANES];

  expect_t            exp_q [$];
  expect_t            cmp_exp;
  int                 n_lookups;
  int                 n_checked;
  int                 seed;
  logic               rb_v   [2];
  logic [27:0]        rb_blk [2];

  bp_top i_bp_top (.*);

  bind bp_top bp_props u_props (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_s0_valid         (i_s0_valid),
    .i_s2_valid         (o_s2_valid),
    .i_s2_predict_valid (o_s2_predict_valid),
    .i_s2_taken_lanes   (o_s2_taken_lanes)
  );

  always #(CLK_PERIOD_NS / 2) i_clk = ~i_clk;

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR: time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      stop_run();
    end
  endtask

  // ------------------------------
  // reference model, one call per clock
  // ------------------------------
  function automatic void bp_model_predict();
    expect_t      e;
    bp_pkg::bhr_t chain;
    bp_pkg::bhr_t idx0;
    logic [1:0]   upd;
    logic [1:0]   lane;
    logic [3:0]   bi;
    logic         spec;
    e     = '0;
    chain = m_bhr;
    spec  = 1'b0;
    // lookup in s1 resolves into the s2 result
    if (m1_valid) begin
      e.index = m1_index;
      for (int c = 0; c < `BP_LANES; c++) begin
        e.bhr[c] = chain;
        e.ctr[c] = m1_ctr[c];
        if (m1_hit[c] && m1_ctr[c][1] && !e.pv) begin
          e.pv       = 1'b1;
          e.taken[c] = 1'b1;
          e.tgt      = m1_tgt[c];
        end
        if (m1_hit[c] && m1_cond[c]) begin
          chain = {chain[`BP_BHR_W-2:0], m1_ctr[c][1]};
          spec  = 1'b1;
        end
      end
      exp_q.push_back(e);
    end
    if (st_c_taken) begin
      upd = (st_c_ctr == 2'd3) ? 2'd3 : st_c_ctr + 2'd1;
    end else begin
      upd = (st_c_ctr == 2'd0) ? 2'd0 : st_c_ctr - 2'd1;
    end
    lane = st_c_pc[3:2];
    // s0 read, counters see this cycle's training, the BTB does not
    idx0 = m_bhr ^ st_pc[9:4];
    bi   = st_pc[7:4];
    for (int c = 0; c < `BP_LANES; c++) begin
      if (st_c_v && st_c_cond && lane == 2'(c) && st_c_idx == idx0) begin
        m1_ctr[c] = upd;
      end else begin
        m1_ctr[c] = m_ctr[c][idx0];
      end
      m1_hit[c]  = st_s0_v && m_bv[c][bi] && (m_btag[c][bi] == st_pc[31:8]);
      m1_cond[c] = m_bcond[c][bi];
      m1_tgt[c]  = m_btgt[c][bi];
    end
    m1_valid = st_s0_v;
    m1_index = idx0;
    if (st_c_v && st_c_cond) begin
      m_ctr[lane][st_c_idx] = upd;
    end
    if (st_c_v && st_c_taken) begin
      m_bv[lane][st_c_pc[7:4]]    = 1'b1;
      m_btag[lane][st_c_pc[7:4]]  = st_c_pc[31:8];
      m_btgt[lane][st_c_pc[7:4]]  = st_c_tgt;
      m_bcond[lane][st_c_pc[7:4]] = st_c_cond;
    end
    // rollback wins over the speculative history
    if (st_c_v && st_c_cond && st_c_mis) begin
      m_bhr = {st_c_bhr[`BP_BHR_W-2:0], st_c_taken};
    end else if (spec) begin
      m_bhr = chain;
    end
  endfunction

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  task automatic stage_lookup(input bp_pkg::vaddr_t pc);
    st_s0_v = 1'b1;
    st_pc   = pc;
  endtask

  // reported index, counter and history come from the shadow state
  task automatic stage_commit(input bp_pkg::vaddr_t pc, input logic cond,
                              input logic taken, input logic mis,
                              input bp_pkg::vaddr_t tgt);
    st_c_v     = 1'b1;
    st_c_pc    = pc;
    st_c_cond  = cond;
    st_c_taken = taken;
    st_c_mis   = mis;
    st_c_tgt   = tgt;
    st_c_idx   = m_bhr ^ pc[9:4];
    st_c_ctr   = m_ctr[pc[3:2]][st_c_idx];
    st_c_bhr   = m_bhr;
  endtask

  task automatic drive_cycle();
    @(posedge i_clk);
    i_s0_valid       <= st_s0_v;
    i_s0_pc          <= st_pc;
    i_cmt_valid      <= st_c_v;
    i_cmt_pc         <= st_c_pc;
    i_cmt_is_cond    <= st_c_cond;
    i_cmt_taken      <= st_c_taken;
    i_cmt_mispredict <= st_c_mis;
    i_cmt_target     <= st_c_tgt;
    i_cmt_index      <= st_c_idx;
    i_cmt_ctr        <= bp_pkg::ctr_e'(st_c_ctr);
    i_cmt_bhr        <= st_c_bhr;
    bp_model_predict();
    if (st_s0_v) begin
      n_lookups++;
    end
    rb_v[1]   = rb_v[0];
    rb_blk[1] = rb_blk[0];
    rb_v[0]   = st_s0_v;
    rb_blk[0] = st_pc[31:4];
    st_s0_v   = 1'b0;
    st_c_v    = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle();
  endtask

  // few tags and sets so that random lookups hit
  function automatic bp_pkg::vaddr_t random_pc();
    int r;
    r = $random(seed);
    return {23'h000001, r[0], 2'b00, r[2:1], r[4:3], 2'b00};
  endfunction

  function automatic logic near_lookup(input bp_pkg::vaddr_t pc);
    return (rb_v[0] && rb_blk[0] == pc[31:4]) || (rb_v[1] && rb_blk[1] == pc[31:4]);
  endfunction

  // ------------------------------
  // compare at s2
  // ------------------------------
  always @(negedge i_clk) begin
    if (i_reset_n && o_s2_valid) begin
      if (exp_q.size() == 0) begin
        $display("o_s2_valid is high at time %0t with no lookup outstanding", $time);
        stop_run();
      end else begin
        cmp_exp = exp_q.pop_front();
        check_value("o_s2_predict_valid", 32'(o_s2_predict_valid), 32'(cmp_exp.pv));
        check_value("o_s2_predict_target", o_s2_predict_target, cmp_exp.tgt);
        check_value("o_s2_taken_lanes", 32'(o_s2_taken_lanes), 32'(cmp_exp.taken));
        for (int c = 0; c < `BP_LANES; c++) begin
          check_value($sformatf("o_s2_index[%0d]", c), 32'(o_s2_index[c]),
                      32'(cmp_exp.index));
          check_value($sformatf("o_s2_ctr[%0d]", c), 32'(o_s2_ctr[c]),
                      32'(cmp_exp.ctr[c]));
          check_value($sformatf("o_s2_bhr[%0d]", c), 32'(o_s2_bhr[c]),
                      32'(cmp_exp.bhr[c]));
        end
        n_checked++;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("watchdog expired, the predictor stopped returning lookup results");
    stop_run();
  end

  initial begin
    int             r;
    bp_pkg::vaddr_t cpc;
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    i_s0_valid = 1'b0;
    i_s0_pc = '0;
    i_cmt_valid = 1'b0;
    i_cmt_pc = '0;
    i_cmt_is_cond = 1'b0;
    i_cmt_taken = 1'b0;
    i_cmt_mispredict = 1'b0;
    i_cmt_target = '0;
    i_cmt_index = '0;
    i_cmt_ctr = bp_pkg::WEAK_T;
    i_cmt_bhr = '0;
    {st_s0_v, st_c_v, st_c_cond, st_c_taken, st_c_mis} = '0;
    {st_pc, st_c_pc, st_c_tgt, st_c_idx, st_c_ctr, st_c_bhr} = '0;
    m_bhr = '0;
    m1_valid = 1'b0;
    rb_v = '{1'b0, 1'b0};
    rb_blk = '{28'd0, 28'd0};
    n_lookups = 0;
    n_checked = 0;
    seed = 25216;
    for (int c = 0; c < `BP_LANES; c++) begin
      for (int i = 0; i < TABLE_N; i++) begin
        m_ctr[c][i] = 2'd2;
      end
      for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
        m_bv[c][i] = 1'b0;
        m_bcond[c][i] = 1'b0;
        m_btag[c][i] = '0;
        m_btgt[c][i] = '0;
      end
    end
    repeat (3) @(posedge i_clk);
    i_reset_n <= 1'b1;

    // empty predictor, no hits anywhere
    stage_lookup(32'h0000_1230);
    drive_cycle();
    stage_lookup(32'h0000_5670);
    idle_cycles(3);

    // lanes 1 and 2 conditional, lane 3 unconditional
    stage_commit(32'h0000_1238, 1'b1, 1'b1, 1'b0, 32'h0000_4000);
    drive_cycle();
    stage_commit(32'h0000_1234, 1'b1, 1'b1, 1'b0, 32'h0000_5000);
    drive_cycle();
    stage_commit(32'h0000_123c, 1'b0, 1'b1, 1'b0, 32'h0000_6000);
    drive_cycle();
    stage_lookup(32'h0000_1230);
    idle_cycles(4);

    // train one lane down to strongly not taken and past it
    stage_commit(32'h0000_2340, 1'b1, 1'b1, 1'b0, 32'h0000_7000);
    drive_cycle();
    repeat (5) begin
      stage_commit(32'h0000_2340, 1'b1, 1'b0, 1'b0, 32'h0000_7000);
      drive_cycle();
    end
    stage_lookup(32'h0000_2340);
    idle_cycles(4);

    // chained history over back-to-back lookups
    stage_lookup(32'h0000_1230);
    drive_cycle();
    stage_lookup(32'h0000_1230);
    drive_cycle();
    stage_lookup(32'h0000_2340);
    idle_cycles(4);

    // rollback, then a lookup on the restored history
    stage_commit(32'h0000_1234, 1'b1, 1'b0, 1'b1, 32'h0000_5000);
    drive_cycle();
    stage_lookup(32'h0000_1230);
    idle_cycles(3);

    for (int i = 0; i < N_RANDOM; i++) begin
      r = $random(seed);
      cpc = random_pc();
      if (r[0]) begin
        stage_lookup(random_pc());
      end
      if (r[1] && !near_lookup(cpc)) begin
        stage_commit(cpc, r[2], r[3], r[4], bp_pkg::vaddr_t'($random(seed)) & 32'hffff_fffc);
      end
      drive_cycle();
    end

    while (n_checked < n_lookups) begin
      drive_cycle();
    end
    drive_cycle();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/bp_pkg.sv
hw/btb/bp_btb.sv
hw/gshare/bp_gshare.sv
hw/gshare/bp_taken_select.sv
hw/bp_top.sv
verification/bp_props.sv
verification/bp_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the predictor testbench with Verilator and run it
# exit status is non-zero when the simulation fails
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module bp_tb \
  -f project.f \
  -o bp_tb_sim

./obj_dir/bp_tb_sim
